/* cpu_config.svh */
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// Datapath widths
`define CPU_DATA_W      8
`define CPU_INSTR_W     16
`define CPU_ADDR_W      8

// General register file
`define CPU_NUM_REGS    4
`define CPU_REG_SEL_W   2

// Instruction fields
`define CPU_OPCODE_W    4

// T-state sequencing, T0 and T1 fetch, T2 executes
`define CPU_T_STATE_W          2
`define CPU_CYCLES_PER_INSTR   3

`endif

/* cpuPkg.sv */
`include "cpu_config.svh"

package cpuPkg;

    typedef logic [`CPU_DATA_W-1:0]    data_t;
    typedef logic [`CPU_ADDR_W-1:0]    addr_t;
    typedef logic [`CPU_INSTR_W-1:0]   instr_t;
    typedef logic [`CPU_REG_SEL_W-1:0] regSel_t;

    // Unlisted opcodes run as no-ops
    typedef enum logic [`CPU_OPCODE_W-1:0] {
        opAnd = 4'd0,
        opOr  = 4'd1,
        opNot = 4'd2,
        opAdd = 4'd3,
        opSub = 4'd4,
        opBra = 4'd9,
        opMov = 4'd11,
        opLd  = 4'd12,
        opSt  = 4'd13
    } opcode_e;

    typedef enum logic [`CPU_T_STATE_W-1:0] {
        t0 = 2'd0,  // High instruction byte
        t1 = 2'd1,  // Low instruction byte
        t2 = 2'd2   // Execute
    } tState_e;

    typedef enum logic [2:0] {
        aluAnd  = 3'd0,
        aluOr   = 3'd1,
        aluNot  = 3'd2,
        aluAdd  = 3'd3,
        aluSub  = 3'd4,
        aluPass = 3'd5
    } aluOp_e;

    typedef enum logic [1:0] {
        wbAlu = 2'd0,
        wbImm = 2'd1,
        wbMem = 2'd2
    } wbSel_e;

    typedef struct packed {
        logic    regWrite;
        regSel_t writeReg;
        regSel_t readA;
        regSel_t readB;
        aluOp_e  aluOp;
        wbSel_e  wbSel;
        logic    memWrite;
        logic    pcLoad;
    } ctrlWord_t;

endpackage

/* fetchUnit.sv */
`timescale 1ns/10ps
`include "cpu_config.svh"

module fetchUnit (
    input  logic              clock,
    input  logic              arstN,
    input  cpuPkg::ctrlWord_t ctrl,
    input  cpuPkg::data_t     wbData,
    input  cpuPkg::data_t     memRdData,
    output cpuPkg::tState_e   state,
    output cpuPkg::instr_t    instr,
    output cpuPkg::addr_t     memAddr
);

    cpuPkg::addr_t pc;

    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            state <= cpuPkg::t0;
        end else begin
            case (state)
                cpuPkg::t0: state <= cpuPkg::t1;
                cpuPkg::t1: state <= cpuPkg::t2;
                default:    state <= cpuPkg::t0;
            endcase
        end
    end

    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            pc <= '0;
        end else if (state == cpuPkg::t2) begin
            if (ctrl.pcLoad) begin
                pc <= wbData;  // Branch target
            end
        end else begin
            pc <= pc + 1'b1;  // Wraps at 256
        end
    end

    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            instr <= '0;
        end else if (state == cpuPkg::t0) begin
            instr[`CPU_INSTR_W-1 -: `CPU_DATA_W] <= memRdData;
        end else if (state == cpuPkg::t1) begin
            instr[`CPU_DATA_W-1:0] <= memRdData;
        end
    end

    // Execute cycle addresses the operand byte of LD, ST and BRA
    assign memAddr = (state == cpuPkg::t2) ? instr[`CPU_ADDR_W-1:0] : pc;

    stateLegal: assert property (
        @(posedge clock) disable iff (!arstN)
        state inside {cpuPkg::t0, cpuPkg::t1, cpuPkg::t2}
    );

endmodule

/* decodeUnit.sv */
`timescale 1ns/10ps

module decodeUnit (
    input  cpuPkg::tState_e   state,
    input  cpuPkg::instr_t    instr,
    output cpuPkg::ctrlWord_t ctrl,
    output logic              memWrite
);

    cpuPkg::opcode_e opcode;
    logic            directMode;

    assign opcode     = cpuPkg::opcode_e'(instr[15:12]);
    assign directMode = instr[10];

    always_comb begin
        ctrl          = '0;
        ctrl.writeReg = instr[9:8];  // Dst field and LD register share these bits
        ctrl.readA    = instr[5:4];
        ctrl.readB    = instr[1:0];
        ctrl.aluOp    = cpuPkg::aluPass;
        ctrl.wbSel    = cpuPkg::wbAlu;
        if (state == cpuPkg::t2) begin
            case (opcode)
                cpuPkg::opAnd: begin
                    ctrl.aluOp    = cpuPkg::aluAnd;
                    ctrl.regWrite = 1'b1;
                end
                cpuPkg::opOr: begin
                    ctrl.aluOp    = cpuPkg::aluOr;
                    ctrl.regWrite = 1'b1;
                end
                cpuPkg::opNot: begin
                    ctrl.aluOp    = cpuPkg::aluNot;
                    ctrl.regWrite = 1'b1;
                end
                cpuPkg::opAdd: begin
                    ctrl.aluOp    = cpuPkg::aluAdd;
                    ctrl.regWrite = 1'b1;
                end
                cpuPkg::opSub: begin
                    ctrl.aluOp    = cpuPkg::aluSub;
                    ctrl.regWrite = 1'b1;
                end
                cpuPkg::opMov: begin
                    ctrl.regWrite = 1'b1;  // Pass of src1
                end
                cpuPkg::opLd: begin
                    ctrl.wbSel    = directMode ? cpuPkg::wbMem : cpuPkg::wbImm;
                    ctrl.regWrite = 1'b1;
                end
                cpuPkg::opSt: begin
                    ctrl.readB    = instr[9:8];  // Store data on port B
                    ctrl.memWrite = 1'b1;
                end
                cpuPkg::opBra: begin
                    ctrl.wbSel  = directMode ? cpuPkg::wbMem : cpuPkg::wbImm;
                    ctrl.pcLoad = 1'b1;
                end
                default: begin
                end
            endcase
        end
        strobesInT2: assert (state == cpuPkg::t2
            || !(ctrl.regWrite || ctrl.memWrite || ctrl.pcLoad));
    end

    assign memWrite = ctrl.memWrite;

endmodule

/* registerFile.sv */
`timescale 1ns/10ps
`include "cpu_config.svh"

module registerFile (
    input  logic              clock,
    input  logic              arstN,
    input  cpuPkg::ctrlWord_t ctrl,
    input  cpuPkg::data_t     wbData,
    output cpuPkg::data_t     rdDataA,
    output cpuPkg::data_t     rdDataB
);

    cpuPkg::data_t regValue [`CPU_NUM_REGS];

    for (genvar i = 0; i < `CPU_NUM_REGS; i++) begin : genReg
        cpuPkg::data_t value;

        always_ff @(posedge clock or negedge arstN) begin
            if (!arstN) begin
                value <= '0;
            end else if (ctrl.regWrite && ctrl.writeReg == cpuPkg::regSel_t'(i)) begin
                value <= wbData;
            end
        end

        assign regValue[i] = value;
    end

    // Reads see the old value during a write cycle
    assign rdDataA = regValue[ctrl.readA];
    assign rdDataB = regValue[ctrl.readB];

endmodule

/* executeUnit.sv */
`timescale 1ns/10ps

module executeUnit (
    input  cpuPkg::ctrlWord_t ctrl,
    input  cpuPkg::instr_t    instr,
    input  cpuPkg::data_t     rdDataA,
    input  cpuPkg::data_t     rdDataB,
    input  cpuPkg::data_t     memRdData,
    output cpuPkg::data_t     wbData,
    output cpuPkg::data_t     memWrData
);

    cpuPkg::data_t aluResult;

    always_comb begin
        case (ctrl.aluOp)
            cpuPkg::aluAnd: aluResult = rdDataA & rdDataB;
            cpuPkg::aluOr:  aluResult = rdDataA | rdDataB;
            cpuPkg::aluNot: aluResult = ~rdDataA;
            cpuPkg::aluAdd: aluResult = rdDataA + rdDataB;  // Carry dropped
            cpuPkg::aluSub: aluResult = rdDataA - rdDataB;
            default:        aluResult = rdDataA;
        endcase
    end

    always_comb begin
        case (ctrl.wbSel)
            cpuPkg::wbImm: wbData = instr[7:0];
            cpuPkg::wbMem: wbData = memRdData;  // Byte at the IR low address
            default:       wbData = aluResult;
        endcase
    end

    assign memWrData = rdDataB;

endmodule

/* cpuCore.sv */
`timescale 1ns/10ps

module cpuCore (
    input  logic          clock,
    input  logic          arstN,
    input  cpuPkg::data_t memRdData,
    output cpuPkg::addr_t memAddr,
    output cpuPkg::data_t memWrData,
    output logic          memWrite
);

    cpuPkg::ctrlWord_t ctrl;
    cpuPkg::tState_e   state;
    cpuPkg::instr_t    instr;
    cpuPkg::data_t     wbData;
    cpuPkg::data_t     rdDataA;
    cpuPkg::data_t     rdDataB;

    fetchUnit uFetch (
        .clock     (clock),
        .arstN     (arstN),
        .ctrl      (ctrl),
        .wbData    (wbData),
        .memRdData (memRdData),
        .state     (state),
        .instr     (instr),
        .memAddr   (memAddr)
    );

    decodeUnit uDecode (
        .state    (state),
        .instr    (instr),
        .ctrl     (ctrl),
        .memWrite (memWrite)
    );

    registerFile uRegs (
        .clock   (clock),
        .arstN   (arstN),
        .ctrl    (ctrl),
        .wbData  (wbData),
        .rdDataA (rdDataA),
        .rdDataB (rdDataB)
    );

    executeUnit uExec (
        .ctrl      (ctrl),
        .instr     (instr),
        .rdDataA   (rdDataA),
        .rdDataB   (rdDataB),
        .memRdData (memRdData),
        .wbData    (wbData),
        .memWrData (memWrData)
    );

endmodule

/* cpuCoreTb.sv */
`timescale 1ns/10ps
`include "cpu_config.svh"

module cpuCoreTb;

    localparam int memDepth    = 1 << `CPU_ADDR_W;
    localparam int numInstr    = 300;
    localparam int maxCycles   = numInstr * `CPU_CYCLES_PER_INSTR + 30;
    localparam int resetCycles = 5;

    localparam logic [3:0] opAnd = 4'd0;
    localparam logic [3:0] opOr  = 4'd1;
    localparam logic [3:0] opNot = 4'd2;
    localparam logic [3:0] opAdd = 4'd3;
    localparam logic [3:0] opSub = 4'd4;
    localparam logic [3:0] opBra = 4'd9;
    localparam logic [3:0] opMov = 4'd11;
    localparam logic [3:0] opLd  = 4'd12;
    localparam logic [3:0] opSt  = 4'd13;

    logic          clock;
    logic          arstN;
    cpuPkg::data_t memRdData;
    cpuPkg::addr_t memAddr;
    cpuPkg::data_t memWrData;
    logic          memWrite;

    cpuPkg::data_t mem      [memDepth];  // Memory on the DUT bus
    cpuPkg::data_t modelMem [memDepth];
    cpuPkg::data_t modelReg [`CPU_NUM_REGS];
    cpuPkg::addr_t modelPc;

    int mismatchCount;
    int otherErrors;
    int stCount;
    int braCount;
    int nopCount;

    cpuCore dut_i (
        .clock     (clock),
        .arstN     (arstN),
        .memRdData (memRdData),
        .memAddr   (memAddr),
        .memWrData (memWrData),
        .memWrite  (memWrite)
    );

    initial clock = 1'b0;
    always #2 clock = ~clock;

    // Biased toward LD and ST so stores show register contents often
    function automatic cpuPkg::data_t instrByte();
        logic [3:0] opcode;
        case ($urandom_range(0, 7))
            0:       opcode = opSt;
            1:       opcode = opLd;
            default: opcode = 4'($urandom_range(0, 15));
        endcase
        return {opcode, 4'($urandom_range(0, 15))};
    endfunction

    task automatic fillMemory();
        for (int a = 0; a < memDepth; a++) begin
            if (a % 2 == 0) begin
                mem[a] = instrByte();
            end else begin
                mem[a] = 8'($urandom());
            end
            modelMem[a] = mem[a];
        end
    endtask

    task automatic reportMismatch(input string what, input cpuPkg::data_t got,
                                  input cpuPkg::data_t expected);
        mismatchCount++;
        $display("MISMATCH at %0t: %s is %02h, expected %02h", $time, what, got, expected);
    endtask

    task automatic checkFetch(input cpuPkg::addr_t expAddr, input string cycleName);
        if (memAddr !== expAddr) begin
            reportMismatch({cycleName, " fetch address"}, memAddr, expAddr);
        end
        if (memWrite !== 1'b0) begin
            reportMismatch({cycleName, " memWrite"}, cpuPkg::data_t'(memWrite), 8'd0);
        end
    endtask

    task automatic checkExecute(input cpuPkg::instr_t instr);
        logic            expWrite;
        cpuPkg::addr_t   operand;
        cpuPkg::regSel_t dst;
        expWrite = (instr[15:12] == opSt);
        operand  = instr[7:0];
        dst      = instr[9:8];
        if (memAddr !== operand) begin
            reportMismatch("T2 operand address", memAddr, operand);
        end
        if (memWrite !== expWrite) begin
            reportMismatch("T2 memWrite", cpuPkg::data_t'(memWrite),
                           cpuPkg::data_t'(expWrite));
        end
        if (expWrite && memWrData !== modelReg[dst]) begin
            reportMismatch("ST data", memWrData, modelReg[dst]);
        end
    endtask

    task automatic stepModel(input cpuPkg::instr_t instr);
        logic [3:0]      opcode;
        cpuPkg::regSel_t dst;
        cpuPkg::regSel_t srcA;
        cpuPkg::regSel_t srcB;
        cpuPkg::data_t   operand;
        cpuPkg::data_t   loaded;
        opcode  = instr[15:12];
        dst     = instr[9:8];
        srcA    = instr[5:4];
        srcB    = instr[1:0];
        operand = instr[7:0];
        loaded  = instr[10] ? modelMem[operand] : operand;  // Direct or immediate
        modelPc = modelPc + 8'd2;
        case (opcode)
            opAnd: modelReg[dst] = modelReg[srcA] & modelReg[srcB];
            opOr:  modelReg[dst] = modelReg[srcA] | modelReg[srcB];
            opNot: modelReg[dst] = ~modelReg[srcA];
            opAdd: modelReg[dst] = modelReg[srcA] + modelReg[srcB];
            opSub: modelReg[dst] = modelReg[srcA] - modelReg[srcB];
            opMov: modelReg[dst] = modelReg[srcA];
            opLd:  modelReg[dst] = loaded;
            opSt: begin
                modelMem[operand] = modelReg[dst];
                stCount++;
            end
            opBra: begin
                modelPc = loaded;
                braCount++;
            end
            default: nopCount++;  // Dropped opcodes change nothing
        endcase
    endtask

    initial begin
        int             phase;
        int             cycles;
        int             instrCount;
        logic           writePending;
        cpuPkg::addr_t  writeAddr;
        cpuPkg::data_t  writeData;
        cpuPkg::instr_t curInstr;

        void'($urandom(64));
        mismatchCount = 0;
        otherErrors   = 0;
        stCount       = 0;
        braCount      = 0;
        nopCount      = 0;
        arstN         = 1'b0;
        memRdData     = '0;
        modelPc       = '0;
        curInstr      = '0;
        writePending  = 1'b0;
        writeAddr     = '0;
        writeData     = '0;
        for (int r = 0; r < `CPU_NUM_REGS; r++) begin
            modelReg[r] = '0;
        end
        fillMemory();

        for (int i = 0; i < resetCycles; i++) begin
            @(posedge clock);
        end
        #1;
        arstN = 1'b1;
        checkFetch(8'd0, "After reset");

        phase      = 0;
        cycles     = 0;
        instrCount = 0;
        while (instrCount < numInstr && cycles < maxCycles) begin
            if (phase == 0) begin
                checkFetch(modelPc, "T0");
            end else if (phase == 1) begin
                checkFetch(modelPc + 8'd1, "T1");
            end else begin
                curInstr = {modelMem[modelPc], modelMem[modelPc + 8'd1]};
                checkExecute(curInstr);
            end
            if (memWrite === 1'b1) begin
                writePending = 1'b1;  // Lands at the next edge
                writeAddr    = memAddr;
                writeData    = memWrData;
            end
            memRdData = mem[memAddr];
            @(posedge clock);
            #1;
            if (writePending) begin
                mem[writeAddr] = writeData;
                writePending   = 1'b0;
            end
            if (phase == 2) begin
                stepModel(curInstr);
                instrCount++;
                phase = 0;
            end else begin
                phase++;
            end
            cycles++;
        end

        if (instrCount < numInstr) begin
            otherErrors++;
            $display("Timeout: only %0d of %0d instructions completed", instrCount, numInstr);
        end
        if (stCount == 0) begin
            otherErrors++;
            $display("No ST instruction ran, so register results were never checked");
        end
        $display("Ran %0d instructions: %0d ST, %0d BRA, %0d no-ops",
                 instrCount, stCount, braCount, nopCount);
        $display("Errors: %0d mismatches, %0d other failures", mismatchCount, otherErrors);
        if (mismatchCount == 0 && otherErrors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* verilog.f */
+incdir+.
cpuPkg.sv
fetchUnit.sv
decodeUnit.sv
registerFile.sv
executeUnit.sv
cpuCore.sv
cpuCoreTb.sv

/* run.sh */
#!/bin/bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -f verilog.f --top-module cpuCoreTb
./obj_dir/VcpuCoreTb | tee sim.log

if grep -q "Done: errors found" sim.log; then
    echo "Simulation FAILED"
    exit 1
fi
echo "Simulation PASSED"
